// File: hw/cpu_bus_pkg.sv
// Microarchitecture package with bus selects and the control word and memory request layouts
`include "cpu_macros.svh"
`default_nettype none

package cpu_bus_pkg;

    import cpu_isa_pkg::*;

    // Bus 1 sources
    typedef enum logic [1:0] {
        B1_REG = 2'd0,  // Register file read port
        B1_PC  = 2'd1,  // Zero extended PC
        B1_IMM = 2'd2   // Extended immediate
    } bus1_sel_t;

    // Bus 2 sources
    typedef enum logic [1:0] {
        B2_ALU  = 2'd0,
        B2_BUS1 = 2'd1,
        B2_MEM  = 2'd2  // Read data from memory
    } bus2_sel_t;

    // Memory address source
    typedef enum logic {
        ADDR_PC  = 1'b0,
        ADDR_IMM = 1'b1
    } addr_sel_t;

    // Control word from the FSM to the datapath
    typedef struct packed {
        bus1_sel_t bus1_sel;
        bus2_sel_t bus2_sel;
        addr_sel_t addr_sel;
        logic      sext;            // Sign extend imm8 onto bus 1
        reg_idx_t  rf_rd_addr;
        logic      rf_we;
        reg_idx_t  rf_wr_addr;
        logic      y_ld;            // Latch bus 1 into Y
        opcode_t   alu_op;
        logic      ir_ld;
        logic      pc_inc;
        logic      pc_ld;
        logic      pc_offset_sel;   // PC plus offset instead of bus 1
        logic      mem_write;
    } ctrl_t;

    // Request payload on the memory channel
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] wdata;
        logic                   write;
    } mem_req_t;

endpackage

`default_nettype wire

// File: hw/cpu_control.sv
// Control FSM sequencing fetch, decode, execute, load and store for the 16-bit core
`timescale 1ns/1ps
`default_nettype none

module cpu_control import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  instr_t instr,           // Current IR contents
    input  logic   rd_zero,         // Register read data is zero
    input  logic   mem_req_ready,
    output ctrl_t  ctrl,
    output logic   mem_req_valid,
    output logic   halted
);

    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_FETCH  = 3'd1,
        S_DECODE = 3'd2,
        S_EX     = 3'd3,    // Second cycle of two operand ops
        S_RD     = 3'd4,
        S_WR     = 3'd5,
        S_HALT   = 3'd6
    } state_t;

    state_t  state;
    state_t  next_state;
    opcode_t opcode;

    assign opcode = instr.regs.opcode;
    assign halted = (state == S_HALT);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // Defaults hold every register in the datapath
        ctrl            = '0;
        ctrl.bus1_sel   = B1_REG;
        ctrl.bus2_sel   = B2_ALU;
        ctrl.addr_sel   = ADDR_PC;
        ctrl.alu_op     = opcode;
        ctrl.rf_rd_addr = instr.regs.src1;
        ctrl.rf_wr_addr = instr.regs.dest;
        mem_req_valid   = 1'b0;
        next_state      = state;

        case (state)
            S_IDLE: begin
                next_state = S_FETCH;   // One quiet cycle after reset
            end
            S_FETCH: begin
                mem_req_valid = 1'b1;
                ctrl.addr_sel = ADDR_PC;
                if (mem_req_ready) begin
                    ctrl.ir_ld  = 1'b1;   // IR and PC move on acceptance only
                    ctrl.pc_inc = 1'b1;
                    next_state  = S_DECODE;
                end
            end
            S_DECODE: begin
                next_state = S_FETCH;   // Most ops finish here
                case (opcode)
                    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                        ctrl.y_ld  = 1'b1;  // First operand into Y
                        next_state = S_EX;
                    end
                    OP_NOT, OP_SLA, OP_SRA: begin
                        ctrl.bus2_sel = B2_ALU;
                        ctrl.rf_we    = 1'b1;
                    end
                    OP_LI: begin
                        ctrl.sext     = 1'b1;
                        ctrl.bus1_sel = B1_IMM;
                        ctrl.bus2_sel = B2_BUS1;
                        ctrl.rf_we    = 1'b1;
                    end
                    OP_LW: next_state = S_RD;
                    OP_SW: next_state = S_WR;
                    OP_BIZ: begin
                        ctrl.rf_rd_addr    = instr.regs.dest;   // Test the dest register
                        ctrl.pc_offset_sel = 1'b1;
                        ctrl.pc_ld         = rd_zero;
                    end
                    OP_BNZ: begin
                        ctrl.rf_rd_addr    = instr.regs.dest;
                        ctrl.pc_offset_sel = 1'b1;
                        ctrl.pc_ld         = !rd_zero;
                    end
                    OP_JMP: begin
                        ctrl.pc_offset_sel = 1'b1;  // PC already points past the JMP
                        ctrl.pc_ld         = 1'b1;
                    end
                    OP_HALT: next_state = S_HALT;
                    default: next_state = S_FETCH;  // Reserved opcode does nothing
                endcase
            end
            S_EX: begin
                ctrl.rf_rd_addr = instr.regs.src2;  // Second operand straight to the ALU
                ctrl.bus2_sel   = B2_ALU;
                ctrl.rf_we      = 1'b1;
                next_state      = S_FETCH;
            end
            S_RD: begin
                mem_req_valid = 1'b1;
                ctrl.addr_sel = ADDR_IMM;
                ctrl.bus2_sel = B2_MEM;
                if (mem_req_ready) begin
                    ctrl.rf_we = 1'b1;  // Read data valid in the accepting cycle
                    next_state = S_FETCH;
                end
            end
            S_WR: begin
                mem_req_valid   = 1'b1;
                ctrl.addr_sel   = ADDR_IMM;
                ctrl.mem_write  = 1'b1;
                ctrl.rf_rd_addr = instr.regs.dest;  // Store data from dest via bus 1
                if (mem_req_ready) begin
                    next_state = S_FETCH;
                end
            end
            S_HALT: begin
                next_state = S_HALT;    // No more requests
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu_execute.sv
// Execute unit with the Y operand register the ALU and the bus 2 select
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_execute import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_t                  ctrl,
    input  logic [`CPU_DATA_W-1:0] bus1,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output logic [`CPU_DATA_W-1:0] bus2
);

    logic [`CPU_DATA_W-1:0] y_reg;      // First operand of two operand ops
    logic [`CPU_DATA_W-1:0] alu_res;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            y_reg <= '0;
        end else if (ctrl.y_ld) begin
            y_reg <= bus1;
        end
    end

    always_comb begin
        case (ctrl.alu_op)
            OP_ADD:  alu_res = y_reg + bus1;
            OP_SUB:  alu_res = y_reg - bus1;
            OP_AND:  alu_res = y_reg & bus1;
            OP_OR:   alu_res = y_reg | bus1;
            OP_XOR:  alu_res = y_reg ^ bus1;
            OP_NOT:  alu_res = ~bus1;
            // One bit shifts
            OP_SLA:  alu_res = {bus1[`CPU_DATA_W-2:0], 1'b0};
            OP_SRA:  alu_res = {bus1[`CPU_DATA_W-1], bus1[`CPU_DATA_W-1:1]};  // Keeps sign
            default: alu_res = bus1;    // Pass through
        endcase
    end

    always_comb begin
        case (ctrl.bus2_sel)
            B2_BUS1: bus2 = bus1;
            B2_MEM:  bus2 = mem_rdata;
            default: bus2 = alu_res;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu_fetch_unit.sv
// Fetch unit with PC, IR, immediate extension, bus 1 select and memory request payload
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_fetch_unit import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_t                  ctrl,
    input  logic [`CPU_DATA_W-1:0] rf_rdata,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output instr_t                 instr,
    output logic [`CPU_DATA_W-1:0] bus1,
    output mem_req_t               mem_req
);

    logic [`CPU_ADDR_W-1:0] pc;
    instr_t                 ir;
    logic [`CPU_DATA_W-1:0] imm_sext;
    logic [`CPU_DATA_W-1:0] imm_zext;

    assign instr    = ir;
    assign imm_sext = {{(`CPU_DATA_W-8){ir.imm.imm8[7]}}, ir.imm.imm8};
    assign imm_zext = {{(`CPU_DATA_W-8){1'b0}}, ir.imm.imm8};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (ctrl.pc_ld) begin
                // Branch and jump offsets are relative to the next instruction
                pc <= ctrl.pc_offset_sel ? pc + imm_sext[`CPU_ADDR_W-1:0]
                                         : bus1[`CPU_ADDR_W-1:0];
            end else if (ctrl.pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.ir_ld) begin
                ir <= instr_t'(mem_rdata);
            end
        end
    end

    always_comb begin
        case (ctrl.bus1_sel)
            B1_PC:   bus1 = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, pc};
            B1_IMM:  bus1 = ctrl.sext ? imm_sext : imm_zext;
            default: bus1 = rf_rdata;
        endcase
    end

    // Payload is stable while the FSM waits since PC and IR only move on acceptance
    assign mem_req.addr  = (ctrl.addr_sel == ADDR_IMM) ? imm_zext[`CPU_ADDR_W-1:0] : pc;
    assign mem_req.wdata = bus1;
    assign mem_req.write = ctrl.mem_write;

endmodule

`default_nettype wire

// File: hw/cpu_isa_pkg.sv
// Instruction set package holding the opcode encoding and the instruction word layout
`include "cpu_macros.svh"
`default_nettype none

package cpu_isa_pkg;

    // Opcode in the top nibble of every instruction
    typedef enum logic [3:0] {
        OP_ADD  = 4'b0000,
        OP_SUB  = 4'b0001,
        OP_AND  = 4'b0010,
        OP_OR   = 4'b0011,
        OP_XOR  = 4'b0100,
        OP_NOT  = 4'b0101,
        OP_SLA  = 4'b0110,
        OP_SRA  = 4'b0111,
        OP_LI   = 4'b1000,
        OP_LW   = 4'b1001,
        OP_SW   = 4'b1010,
        OP_BIZ  = 4'b1011,
        OP_BNZ  = 4'b1100,
        OP_HALT = 4'b1101,  // Stops the core for good
        OP_JMP  = 4'b1110,
        OP_RSVD = 4'b1111   // Executes as a no-op
    } opcode_t;

    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

    // Same 16 bits seen as register form or immediate form
    typedef union packed {
        struct packed {
            opcode_t  opcode;
            reg_idx_t dest;
            reg_idx_t src1;
            reg_idx_t src2;
        } regs;
        struct packed {
            opcode_t    opcode;
            reg_idx_t   dest;
            logic [7:0] imm8;   // Immediate value, address or branch offset
        } imm;
    } instr_t;

endpackage

`default_nettype wire

// File: hw/cpu_macros.svh
// Global sizing macros for the 16-bit multicycle core
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and instruction word width
`define CPU_DATA_W 16

// Memory address and program counter width
`define CPU_ADDR_W 8

// Number of general purpose registers
`define CPU_NUM_REGS 16

`endif

// File: hw/cpu_regfile.sv
// Register file with sixteen entries and one combinational read and one clocked write port
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_regfile import cpu_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_t                  ctrl,
    input  logic [`CPU_DATA_W-1:0] wdata,    // Bus 2
    output logic [`CPU_DATA_W-1:0] rdata,
    output logic                   rd_zero   // Zero test for BIZ and BNZ
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rf_we) begin
            regs[ctrl.rf_wr_addr] <= wdata;
        end
    end

    // Read is combinational and sees the value before this edge's write
    assign rdata   = regs[ctrl.rf_rd_addr];
    assign rd_zero = (rdata == '0);

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
// Top level of the 16-bit multicycle core joining the control FSM and the datapath
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_top import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    output mem_req_t               mem_req,
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,     // Valid in the accepting cycle
    output logic                   halted
);

    ctrl_t                  ctrl;
    instr_t                 instr;
    logic                   rd_zero;
    logic [`CPU_DATA_W-1:0] rf_rdata;
    logic [`CPU_DATA_W-1:0] bus1;
    logic [`CPU_DATA_W-1:0] bus2;

    cpu_control control_inst (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .rd_zero       (rd_zero),
        .mem_req_ready (mem_req_ready),
        .ctrl          (ctrl),
        .mem_req_valid (mem_req_valid),
        .halted        (halted)
    );

    cpu_fetch_unit fetch_inst (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .rf_rdata  (rf_rdata),
        .mem_rdata (mem_rdata),
        .instr     (instr),
        .bus1      (bus1),
        .mem_req   (mem_req)
    );

    cpu_regfile regfile_inst (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .wdata   (bus2),
        .rdata   (rf_rdata),
        .rd_zero (rd_zero)
    );

    cpu_execute execute_inst (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .bus1      (bus1),
        .mem_rdata (mem_rdata),
        .bus2      (bus2)
    );

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/cpu_control.sv
hw/cpu_fetch_unit.sv
hw/cpu_regfile.sv
hw/cpu_execute.sv
hw/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

// File: tests/cpu_checker.sv
// Concurrent assertions on the memory handshake and the control word of the core
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import cpu_bus_pkg::*; (
    input logic     clk,
    input logic     rst,
    input ctrl_t    ctrl,
    input mem_req_t mem_req,
    input logic     mem_req_valid,
    input logic     mem_req_ready,
    input logic     halted
);

    int fail_count = 0;     // Read by the testbench

    // Valid and payload hold until the transfer
    hold_until_accept: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
        fail_count = fail_count + 1;
        $error("Request dropped or changed while waiting for ready");
    end

    // IR load never overlaps a register write or a PC load
    ir_ld_alone: assert property (@(posedge clk) disable iff (!rst)
        ctrl.ir_ld |-> !ctrl.rf_we && !ctrl.pc_ld)
    else begin
        fail_count = fail_count + 1;
        $error("ir_ld asserted together with rf_we or pc_ld");
    end

    quiet_after_halt: assert property (@(posedge clk) disable iff (!rst)
        halted |-> !mem_req_valid ##1 halted)
    else begin
        fail_count = fail_count + 1;
        $error("Request seen or halted dropped after halt");
    end

endmodule

bind cpu_top cpu_checker checker_inst (
    .clk           (clk),
    .rst           (rst),
    .ctrl          (ctrl),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .halted        (halted)
);

`default_nettype wire

// File: tests/cpu_tb.sv
// Testbench for the 16-bit core with a back-pressured memory model and data-file driven checks
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_tb import cpu_bus_pkg::*; ();

    logic                   clk;
    logic                   rst;
    mem_req_t               mem_req;
    logic                   mem_req_valid;
    logic                   mem_req_ready;
    logic [`CPU_DATA_W-1:0] mem_rdata;
    logic                   halted;

    logic [`CPU_DATA_W-1:0] mem [2**`CPU_ADDR_W];  // Unified program and data memory
    mem_req_t               exp_stores [$];         // Stores in program order
    mem_req_t               last_req;               // Last accepted request
    logic [`CPU_ADDR_W-1:0] exp_halt_addr;
    integer                 seed;
    int                     image_words;
    int                     timeout_limit;
    int                     cycle_count;
    int                     error_count;

    cpu_top cpu_top_inst (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rdata     (mem_rdata),
        .halted        (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    // Reports the reason and ends the run
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_store(input mem_req_t got, input mem_req_t exp);
        if (got.addr !== exp.addr) begin
            abort_run($sformatf("Mismatch mem_req.addr: got %h expected %h", got.addr, exp.addr));
        end
        if (got.wdata !== exp.wdata) begin
            abort_run($sformatf("Mismatch mem_req.wdata at %h: got %h expected %h",
                                got.addr, got.wdata, exp.wdata));
        end
    endtask

    task automatic check_halt(input logic [`CPU_ADDR_W-1:0] got,
                              input logic [`CPU_ADDR_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch halt fetch mem_req.addr: got %h expected %h", got, exp));
        end
    endtask

    // Tags are M for four image words, S for an expected store, H for the halt fetch
    task automatic load_test_file();
        int                     fd;
        int                     rc;
        byte                    tag;
        logic [8*128-1:0]       rest;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] w [4];
        mem_req_t               exp;
        for (int i = 0; i < 2**`CPU_ADDR_W; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};     // Fill differs at every address
        end
        fd = $fopen("tests/cpu_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the data file tests/cpu_tests.txt");
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": rc = $fgets(rest, fd);  // Comment line
                "M": begin
                    rc = $fscanf(fd, "%h %h %h %h %h", addr, w[0], w[1], w[2], w[3]);
                    if (rc != 5) begin
                        abort_run("Data file holds a malformed M line");
                    end
                    for (int i = 0; i < 4; i++) begin
                        mem[addr + i] = w[i];
                    end
                    image_words += 4;
                end
                "S": begin
                    rc = $fscanf(fd, "%h %h", addr, w[0]);
                    if (rc != 2) begin
                        abort_run("Data file holds a malformed S line");
                    end
                    exp.addr  = addr;
                    exp.wdata = w[0];
                    exp.write = 1'b1;
                    exp_stores.push_back(exp);
                end
                "H": begin
                    rc = $fscanf(fd, "%h", exp_halt_addr);
                    if (rc != 1) begin
                        abort_run("Data file holds a malformed H line");
                    end
                end
                default: abort_run("Data file holds a line with an unknown tag");
            endcase
        end
        $fclose(fd);
    endtask

    // Memory model driving ready and read data on the falling edge
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            abort_run("Timeout: the core did not halt within the cycle limit");
        end
        if (cpu_top_inst.checker_inst.fail_count != 0) begin
            abort_run("An assertion in the bound checker failed");
        end
        mem_req_ready = ({$random(seed)} % 3) != 0;   // Back-pressure a third of the time
        mem_rdata     = mem[mem_req.addr];
        if (mem_req_valid && mem_req_ready) begin  // Transfer on the next rising edge
            last_req = mem_req;
            if (mem_req.write) begin
                if (exp_stores.size() == 0) begin
                    abort_run($sformatf("Store to address %h was not expected", mem_req.addr));
                end
                check_store(mem_req, exp_stores.pop_front());
                mem[mem_req.addr] = mem_req.wdata;
            end
        end
    end

    initial begin
        seed          = 32'ha4093aed;
        rst           = 1'b0;
        mem_req_ready = 1'b0;
        mem_rdata     = '0;
        last_req      = '0;
        image_words   = 0;
        cycle_count   = 0;
        error_count   = 0;
        load_test_file();
        timeout_limit = 40 * image_words + 200;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        if (last_req.write) begin
            abort_run("Last accepted request before halt was a store");
        end
        check_halt(last_req.addr, exp_halt_addr);
        repeat (4) @(negedge clk);  // Bus stays quiet while halted
        if (exp_stores.size() != 0) begin
            $display("%0d expected stores never reached memory", exp_stores.size());
            error_count++;
        end
        if (cpu_top_inst.checker_inst.fail_count != 0) begin
            $display("An assertion in the bound checker failed");
            error_count++;
        end
        if (error_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "Run ended with errors");
        end
    end

endmodule

`default_nettype wire

// File: tests/cpu_tests.txt
# M addr w0 w1 w2 w3 loads four words at addr, S addr data is an expected store in order
# H addr is the expected address of the final HALT fetch, all values in hex
M 00 8105 82FD A1A0 A2A1
M 04 9380 9481 0534 A5A2
M 08 1534 A5A3 2534 A5A4
M 0C 3534 A5A5 4534 A5A6
M 10 5620 A6A7 6620 A6A8
M 14 7620 A6A9 9782 A7AA
M 18 B001 A1B0 C001 A1B1
M 1C C101 A1B2 B101 A2B3
M 20 E002 A1B4 D000 F000
M 24 A3B5 D000 F000 F000
M 80 1234 0F0F BEEF 0000
S A0 0005
S A1 FFFD
S A2 2143
S A3 0325
S A4 0204
S A5 1F3F
S A6 1D3B
S A7 0002
S A8 FFFA
S A9 FFFE
S AA BEEF
S B1 0005
S B3 FFFD
S B5 1234
H 25
